//--- Makefile
# Verilator build and run for the vector ALU testbench

VERILATOR ?= verilator
TOP ?= tb_rvv_alu_other
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/rvv_alu_decode.sv
`timescale 1ns/1ps

module rvv_alu_decode (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    uop_valid,
  input  logic                    uop_vm,
  input  rvv_alu_pkg::rob_entry_t uop_rob_entry,
  input  rvv_alu_pkg::funct6_t    uop_funct6,
  input  rvv_alu_pkg::funct3_t    uop_funct3,
  input  rvv_alu_pkg::eew_e       uop_eew,
  input  rvv_alu_pkg::uop_index_t uop_index,
  input  rvv_alu_pkg::vreg_t      vs1_data,
  input  rvv_alu_pkg::vreg_t      vs2_data,
  input  rvv_alu_pkg::vreg_t      v0_data,
  input  rvv_alu_pkg::xreg_t      rs1_data,
  output logic                    lane_valid,
  output logic                    lane_ignore_vma,
  output rvv_alu_pkg::lane_op_e   lane_op,
  output rvv_alu_pkg::eew_e       lane_eew,
  output rvv_alu_pkg::rob_entry_t lane_rob_entry,
  output rvv_alu_pkg::vreg_t      lane_src1,
  output rvv_alu_pkg::vreg_t      lane_src2,
  output rvv_alu_pkg::lane_mask_t lane_mask [rvv_alu_pkg::num_lanes]
);

  import rvv_alu_pkg::*;

  logic       vec_form;
  logic       minmax_ok;
  logic       merge_ok;
  logic       op_supported;
  lane_op_e   op_next;
  vreg_t      scalar_rep;
  vreg_t      src1_next;
  int         mask_shift;
  logic [vlenb-1:0] mask_slice;
  lane_mask_t mask_next [num_lanes];

  // which funct6 groups a given operand form allows
  always_comb begin
    vec_form = 1'b0;
    minmax_ok = 1'b0;
    merge_ok = 1'b0;
    case (uop_funct3)
      opivv: begin
        vec_form = 1'b1;
        minmax_ok = 1'b1;
        merge_ok = 1'b1;
      end
      opivx: begin
        minmax_ok = 1'b1;
        merge_ok = 1'b1;
      end
      opivi: begin
        merge_ok = 1'b1;
      end
      // OPM forms are handled by the mul and mask units
      opmvv, opmvx: begin
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    op_next = lane_move;
    op_supported = 1'b0;
    case (uop_funct6)
      funct6_vminu: begin
        op_next = lane_minu;
        op_supported = minmax_ok;
      end
      funct6_vmin: begin
        op_next = lane_min;
        op_supported = minmax_ok;
      end
      funct6_vmaxu: begin
        op_next = lane_maxu;
        op_supported = minmax_ok;
      end
      funct6_vmax: begin
        op_next = lane_max;
        op_supported = minmax_ok;
      end
      funct6_vmerge_vmv: begin
        // vm set is vmv.v, vm clear is vmerge
        op_next = uop_vm ? lane_move : lane_merge;
        op_supported = merge_ok;
      end
      default: begin
      end
    endcase
  end

  // scalar splat at element width
  always_comb begin
    case (uop_eew)
      eew8:    scalar_rep = {(vlen / byte_width){rs1_data[byte_width-1:0]}};
      eew16:   scalar_rep = {(vlen / hword_width){rs1_data[hword_width-1:0]}};
      default: scalar_rep = {(vlen / xlen){rs1_data}};
    endcase
  end

  assign src1_next = vec_form ? vs1_data : scalar_rep;

  // v0 slice starts at uop_index * elements per register
  always_comb begin
    case (uop_eew)
      eew8:    mask_shift = uop_index * (vlen / byte_width);
      eew16:   mask_shift = uop_index * (vlen / hword_width);
      default: mask_shift = uop_index * (vlen / word_width);
    endcase
  end

  assign mask_slice = vlenb'(v0_data >> mask_shift);

  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      case (uop_eew)
        eew8:    mask_next[l] = mask_slice[4*l +: 4];
        eew16:   mask_next[l] = lane_mask_t'(mask_slice[2*l +: 2]);
        default: mask_next[l] = lane_mask_t'(mask_slice[l]);
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= uop_valid && op_supported;
    end
  end

  always_ff @(posedge clk) begin
    if (uop_valid) begin
      lane_op <= op_next;
      lane_eew <= uop_eew;
      lane_rob_entry <= uop_rob_entry;
      lane_ignore_vma <= (op_next == lane_merge);
      lane_src1 <= src1_next;
      lane_src2 <= vs2_data;
      lane_mask <= mask_next;
    end
  end

endmodule

//--- hdl/rvv_alu_lane.sv
`timescale 1ns/1ps

module rvv_alu_lane (
  input  rvv_alu_pkg::lane_op_e   op,
  input  rvv_alu_pkg::eew_e       eew,
  input  rvv_alu_pkg::word_t      src1,
  input  rvv_alu_pkg::word_t      src2,
  input  rvv_alu_pkg::lane_mask_t mask,
  output rvv_alu_pkg::word_t      result
);

  import rvv_alu_pkg::*;

  logic is_signed;
  logic is_max;
  logic [3:0][byte_width-1:0]  src1_b;
  logic [3:0][byte_width-1:0]  src2_b;
  logic [1:0][hword_width-1:0] src1_h;
  logic [1:0][hword_width-1:0] src2_h;
  logic [3:0][byte_width-1:0]  minmax8;
  logic [1:0][hword_width-1:0] minmax16;
  word_t      minmax32;
  word_t      minmax_res;
  lane_mask_t byte_sel;
  word_t      merge_res;

  // operands arrive extended by one bit, so one signed compare covers both cases
  function automatic logic src2_wins(
    input logic signed [word_width:0] a,
    input logic signed [word_width:0] b,
    input logic take_max
  );
    return (a < b) ^ take_max;
  endfunction

  assign is_signed = (op == lane_min) || (op == lane_max);
  assign is_max = (op == lane_maxu) || (op == lane_max);

  assign src1_b = src1;
  assign src2_b = src2;
  assign src1_h = src1;
  assign src2_h = src2;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      minmax8[i] = src2_wins($signed({is_signed & src2_b[i][byte_width-1], src2_b[i]}),
                             $signed({is_signed & src1_b[i][byte_width-1], src1_b[i]}),
                             is_max) ? src2_b[i] : src1_b[i];
    end
    for (int i = 0; i < 2; i++) begin
      minmax16[i] = src2_wins($signed({is_signed & src2_h[i][hword_width-1], src2_h[i]}),
                              $signed({is_signed & src1_h[i][hword_width-1], src1_h[i]}),
                              is_max) ? src2_h[i] : src1_h[i];
    end
    minmax32 = src2_wins($signed({is_signed & src2[word_width-1], src2}),
                         $signed({is_signed & src1[word_width-1], src1}),
                         is_max) ? src2 : src1;
  end

  always_comb begin
    case (eew)
      eew8:    minmax_res = minmax8;
      eew16:   minmax_res = minmax16;
      default: minmax_res = minmax32;
    endcase
  end

  // spread element mask bits over the bytes they cover
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      case (eew)
        eew8:    byte_sel[b] = mask[b];
        eew16:   byte_sel[b] = mask[b/2];
        default: byte_sel[b] = mask[0];
      endcase
      merge_res[b*byte_width +: byte_width] = byte_sel[b] ? src1_b[b] : src2_b[b];
    end
  end

  always_comb begin
    case (op)
      lane_merge: result = merge_res;
      lane_move:  result = src1;
      default:    result = minmax_res;
    endcase
  end

endmodule

//--- hdl/rvv_alu_other.sv
`timescale 1ns/1ps

module rvv_alu_other (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    uop_valid,
  input  rvv_alu_pkg::rob_entry_t uop_rob_entry,
  input  rvv_alu_pkg::funct6_t    uop_funct6,
  input  rvv_alu_pkg::funct3_t    uop_funct3,
  input  logic                    uop_vm,
  input  rvv_alu_pkg::eew_e       uop_eew,
  input  rvv_alu_pkg::uop_index_t uop_index,
  input  rvv_alu_pkg::vreg_t      vs1_data,
  input  rvv_alu_pkg::vreg_t      vs2_data,
  input  rvv_alu_pkg::xreg_t      rs1_data,
  input  rvv_alu_pkg::vreg_t      v0_data,
  output logic                    result_valid,
  output rvv_alu_pkg::rob_entry_t result_rob_entry,
  output rvv_alu_pkg::vreg_t      result_data,
  output logic                    result_ignore_vma
);

  import rvv_alu_pkg::*;

  logic       lane_valid;
  logic       lane_ignore_vma;
  lane_op_e   lane_op;
  eew_e       lane_eew;
  rob_entry_t lane_rob_entry;
  vreg_t      lane_src1;
  vreg_t      lane_src2;
  lane_mask_t lane_mask [num_lanes];
  word_t      lane_result [num_lanes];

  rvv_alu_decode u_decode (
    .clk             (clk),
    .rst_n           (rst_n),
    .uop_valid       (uop_valid),
    .uop_vm          (uop_vm),
    .uop_rob_entry   (uop_rob_entry),
    .uop_funct6      (uop_funct6),
    .uop_funct3      (uop_funct3),
    .uop_eew         (uop_eew),
    .uop_index       (uop_index),
    .vs1_data        (vs1_data),
    .vs2_data        (vs2_data),
    .v0_data         (v0_data),
    .rs1_data        (rs1_data),
    .lane_valid      (lane_valid),
    .lane_ignore_vma (lane_ignore_vma),
    .lane_op         (lane_op),
    .lane_eew        (lane_eew),
    .lane_rob_entry  (lane_rob_entry),
    .lane_src1       (lane_src1),
    .lane_src2       (lane_src2),
    .lane_mask       (lane_mask)
  );

  for (genvar l = 0; l < num_lanes; l++) begin : g_lane
    rvv_alu_lane u_lane (
      .op     (lane_op),
      .eew    (lane_eew),
      .src1   (lane_src1[l*word_width +: word_width]),
      .src2   (lane_src2[l*word_width +: word_width]),
      .mask   (lane_mask[l]),
      .result (lane_result[l])
    );
  end

  rvv_alu_writeback u_writeback (
    .clk               (clk),
    .rst_n             (rst_n),
    .lane_valid        (lane_valid),
    .lane_ignore_vma   (lane_ignore_vma),
    .lane_rob_entry    (lane_rob_entry),
    .lane_result       (lane_result),
    .result_valid      (result_valid),
    .result_ignore_vma (result_ignore_vma),
    .result_rob_entry  (result_rob_entry),
    .result_data       (result_data)
  );

endmodule

//--- hdl/rvv_alu_pkg.sv
package rvv_alu_pkg;

  // vector geometry
  localparam int vlen = 128;
  localparam int vlenb = vlen / 8;
  localparam int xlen = 32;
  localparam int word_width = 32;
  localparam int hword_width = 16;
  localparam int byte_width = 8;
  localparam int num_lanes = vlen / word_width;

  // bookkeeping widths
  localparam int rob_depth_width = 4;
  localparam int uop_index_width = 3;

  typedef logic [vlen-1:0] vreg_t;
  typedef logic [xlen-1:0] xreg_t;
  typedef logic [word_width-1:0] word_t;
  // one bit per byte position of a lane word
  typedef logic [word_width/byte_width-1:0] lane_mask_t;
  typedef logic [rob_depth_width-1:0] rob_entry_t;
  typedef logic [uop_index_width-1:0] uop_index_t;
  typedef logic [2:0] funct3_t;
  typedef logic [5:0] funct6_t;

  // operand forms
  localparam funct3_t opivv = 3'b000;
  localparam funct3_t opmvv = 3'b010;
  localparam funct3_t opivi = 3'b011;
  localparam funct3_t opivx = 3'b100;
  localparam funct3_t opmvx = 3'b110;

  // integer arithmetic funct6
  localparam funct6_t funct6_vminu = 6'b000100;
  localparam funct6_t funct6_vmin = 6'b000101;
  localparam funct6_t funct6_vmaxu = 6'b000110;
  localparam funct6_t funct6_vmax = 6'b000111;
  localparam funct6_t funct6_vmerge_vmv = 6'b010111;

  typedef enum logic [1:0] {
    eew8 = 2'b00,
    eew16 = 2'b01,
    eew32 = 2'b10
  } eew_e;

  typedef enum logic [2:0] {
    lane_minu = 3'd0,
    lane_min = 3'd1,
    lane_maxu = 3'd2,
    lane_max = 3'd3,
    lane_merge = 3'd4,
    lane_move = 3'd5
  } lane_op_e;

endpackage

//--- hdl/rvv_alu_writeback.sv
`timescale 1ns/1ps

module rvv_alu_writeback (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    lane_valid,
  input  logic                    lane_ignore_vma,
  input  rvv_alu_pkg::rob_entry_t lane_rob_entry,
  input  rvv_alu_pkg::word_t      lane_result [rvv_alu_pkg::num_lanes],
  output logic                    result_valid,
  output logic                    result_ignore_vma,
  output rvv_alu_pkg::rob_entry_t result_rob_entry,
  output rvv_alu_pkg::vreg_t      result_data
);

  import rvv_alu_pkg::*;

  vreg_t lane_data;

  // lane 0 in the low word
  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      lane_data[l*word_width +: word_width] = lane_result[l];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= lane_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (lane_valid) begin
      result_data <= lane_data;
      result_rob_entry <= lane_rob_entry;
      result_ignore_vma <= lane_ignore_vma;
    end
  end

endmodule

//--- tb.f
+incdir+tests
hdl/rvv_alu_pkg.sv
hdl/rvv_alu_lane.sv
hdl/rvv_alu_decode.sv
hdl/rvv_alu_writeback.sv
hdl/rvv_alu_other.sv
tests/tb_rvv_alu_other.sv

//--- tests/rvv_alu_model.svh
`ifndef RVV_ALU_MODEL_SVH
`define RVV_ALU_MODEL_SVH

function automatic logic model_valid(
  input rvv_alu_pkg::funct6_t funct6,
  input rvv_alu_pkg::funct3_t funct3
);
  logic ivv_ivx;
  ivv_ivx = (funct3 == rvv_alu_pkg::opivv) || (funct3 == rvv_alu_pkg::opivx);
  case (funct6)
    rvv_alu_pkg::funct6_vminu, rvv_alu_pkg::funct6_vmin,
    rvv_alu_pkg::funct6_vmaxu, rvv_alu_pkg::funct6_vmax: return ivv_ivx;
    rvv_alu_pkg::funct6_vmerge_vmv: return ivv_ivx || (funct3 == rvv_alu_pkg::opivi);
    default: return 1'b0;
  endcase
endfunction

function automatic logic model_ignore_vma(
  input rvv_alu_pkg::funct6_t funct6,
  input logic vm
);
  return (funct6 == rvv_alu_pkg::funct6_vmerge_vmv) && !vm;
endfunction

// element-by-element reference for min/max, merge and move
function automatic rvv_alu_pkg::vreg_t model_result(
  input rvv_alu_pkg::funct6_t    funct6,
  input rvv_alu_pkg::funct3_t    funct3,
  input logic                    vm,
  input rvv_alu_pkg::eew_e       eew,
  input rvv_alu_pkg::uop_index_t index,
  input rvv_alu_pkg::vreg_t      vs1,
  input rvv_alu_pkg::vreg_t      vs2,
  input rvv_alu_pkg::xreg_t      rs1,
  input rvv_alu_pkg::vreg_t      v0
);
  int sew;
  int nelem;
  longint a;
  longint b;
  longint elem_mask;
  logic signed_op;
  logic pick_b;
  rvv_alu_pkg::vreg_t res;
  sew = (eew == rvv_alu_pkg::eew8) ? 8 : (eew == rvv_alu_pkg::eew16) ? 16 : 32;
  nelem = rvv_alu_pkg::vlen / sew;
  elem_mask = (longint'(1) << sew) - 1;
  signed_op = (funct6 == rvv_alu_pkg::funct6_vmin) || (funct6 == rvv_alu_pkg::funct6_vmax);
  res = '0;
  for (int e = 0; e < nelem; e++) begin
    a = longint'(vs2 >> (e * sew)) & elem_mask;
    if (funct3 == rvv_alu_pkg::opivv) begin
      b = longint'(vs1 >> (e * sew)) & elem_mask;
    end else begin
      b = longint'(rs1) & elem_mask;
    end
    if (signed_op && a[sew-1]) begin
      a = a - (longint'(1) << sew);
    end
    if (signed_op && b[sew-1]) begin
      b = b - (longint'(1) << sew);
    end
    case (funct6)
      rvv_alu_pkg::funct6_vminu, rvv_alu_pkg::funct6_vmin: pick_b = b < a;
      rvv_alu_pkg::funct6_vmaxu, rvv_alu_pkg::funct6_vmax: pick_b = b > a;
      default: pick_b = vm || v0[index * nelem + e];
    endcase
    res = res | (rvv_alu_pkg::vreg_t'((pick_b ? b : a) & elem_mask) << (e * sew));
  end
  return res;
endfunction

`endif

//--- tests/tb_rvv_alu_other.sv
`timescale 1ns/1ps

module tb_rvv_alu_other;

  import rvv_alu_pkg::*;

  `include "rvv_alu_model.svh"

  localparam int clk_period = 8;
  localparam int n_idle = 10;
  localparam int n_ops = 60;
  localparam int n_unsupported = 40;
  localparam int n_back_to_back = 200;
  localparam int n_drain = 3;
  // reset cycles, every test body, a drain after each of the six tests
  // and one more drain ahead of the result count
  localparam int total_uops = 3 + n_idle + 3 * n_ops + n_unsupported + n_back_to_back
                              + 7 * n_drain;

  typedef struct {
    int         due;
    logic       valid;
    vreg_t      data;
    rob_entry_t rob_entry;
    logic       ignore_vma;
    string      name;
  } expect_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       uop_valid;
  rob_entry_t uop_rob_entry;
  funct6_t    uop_funct6;
  funct3_t    uop_funct3;
  logic       uop_vm;
  eew_e       uop_eew;
  uop_index_t uop_index;
  vreg_t      vs1_data;
  vreg_t      vs2_data;
  xreg_t      rs1_data;
  vreg_t      v0_data;
  logic       result_valid;
  rob_entry_t result_rob_entry;
  vreg_t      result_data;
  logic       result_ignore_vma;

  int         seed = 32'h7568;
  int         edge_count = 0;
  int         pass_count = 0;
  int         fail_count = 0;
  int         test_pass_start;
  int         test_fail_start;
  int         valid_issued = 0;
  int         results_seen = 0;
  rob_entry_t rob_tag = '0;
  expect_t    exp_q [$];
  expect_t    cur;

  rvv_alu_other dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .uop_valid         (uop_valid),
    .uop_rob_entry     (uop_rob_entry),
    .uop_funct6        (uop_funct6),
    .uop_funct3        (uop_funct3),
    .uop_vm            (uop_vm),
    .uop_eew           (uop_eew),
    .uop_index         (uop_index),
    .vs1_data          (vs1_data),
    .vs2_data          (vs2_data),
    .rs1_data          (rs1_data),
    .v0_data           (v0_data),
    .result_valid      (result_valid),
    .result_rob_entry  (result_rob_entry),
    .result_data       (result_data),
    .result_ignore_vma (result_ignore_vma)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic rand_bit();
    return (rand32() % 2) == 1;
  endfunction

  function automatic vreg_t rand_vreg();
    return {rand32(), rand32(), rand32(), rand32()};
  endfunction

  function automatic eew_e rand_eew();
    case (rand32() % 3)
      0:       return eew8;
      1:       return eew16;
      default: return eew32;
    endcase
  endfunction

  // 0..3 pick min/max, anything else the merge/move encoding
  function automatic funct6_t pick_funct6(input int sel);
    case (sel)
      0:       return funct6_vminu;
      1:       return funct6_vmin;
      2:       return funct6_vmaxu;
      3:       return funct6_vmax;
      default: return funct6_vmerge_vmv;
    endcase
  endfunction

  function automatic funct3_t pick_funct3(input int sel);
    case (sel)
      0:       return opivv;
      1:       return opivx;
      default: return opivi;
    endcase
  endfunction

  task automatic check(input string name, input vreg_t expected, input vreg_t actual);
    if (expected !== actual) begin
      $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  // one micro-op per rising edge, expected response due two edges later
  task automatic issue(input logic valid, input funct6_t f6, input funct3_t f3,
                       input logic vm, input eew_e eew, input string name);
    vreg_t      vs1;
    vreg_t      vs2;
    vreg_t      v0;
    xreg_t      rs1;
    uop_index_t idx;
    expect_t    e;
    vs1 = rand_vreg();
    vs2 = rand_vreg();
    v0 = rand_vreg();
    rs1 = rand32();
    idx = uop_index_t'(rand32());
    @(posedge clk);
    edge_count++;
    uop_valid <= valid;
    uop_rob_entry <= rob_tag;
    uop_funct6 <= f6;
    uop_funct3 <= f3;
    uop_vm <= vm;
    uop_eew <= eew;
    uop_index <= idx;
    vs1_data <= vs1;
    vs2_data <= vs2;
    rs1_data <= rs1;
    v0_data <= v0;
    e.due = edge_count + 2;
    e.valid = valid && model_valid(f6, f3);
    e.data = model_result(f6, f3, vm, eew, idx, vs1, vs2, rs1, v0);
    e.rob_entry = rob_tag;
    e.ignore_vma = model_ignore_vma(f6, vm);
    e.name = name;
    exp_q.push_back(e);
    if (e.valid) begin
      valid_issued++;
    end
    rob_tag = rob_tag + rob_entry_t'(1);
  endtask

  task automatic idle(input string name);
    issue(1'b0, pick_funct6(int'(rand32() % 5)), opivv, rand_bit(), rand_eew(), name);
  endtask

  task automatic test_begin();
    test_pass_start = pass_count;
    test_fail_start = fail_count;
  endtask

  task automatic test_end(input string name);
    repeat (n_drain) idle(name);
    $display("test %s done: %0d checks ok, %0d errors", name,
             pass_count - test_pass_start, fail_count - test_fail_start);
  endtask

  task automatic run_minmax(input funct3_t f3, input string name);
    test_begin();
    for (int i = 0; i < n_ops; i++) begin
      issue(1'b1, pick_funct6(int'(rand32() % 4)), f3, rand_bit(), rand_eew(), name);
    end
    test_end(name);
  endtask

  task automatic run_merge_move();
    test_begin();
    for (int i = 0; i < n_ops; i++) begin
      issue(1'b1, funct6_vmerge_vmv, pick_funct3(int'(rand32() % 3)), rand_bit(),
            rand_eew(), "merge_move");
    end
    test_end("merge_move");
  endtask

  task automatic run_unsupported();
    funct6_t f6;
    funct3_t f3;
    test_begin();
    for (int i = 0; i < n_unsupported; i++) begin
      // half of the tries keep a known funct6 with a wrong operand form
      do begin
        f6 = rand_bit() ? pick_funct6(int'(rand32() % 5)) : funct6_t'(rand32());
        f3 = funct3_t'(rand32());
      end while (model_valid(f6, f3));
      issue(1'b1, f6, f3, rand_bit(), rand_eew(), "unsupported");
    end
    test_end("unsupported");
  endtask

  task automatic run_back_to_back();
    funct6_t f6;
    int      issued_before;
    int      seen_before;
    issued_before = valid_issued;
    seen_before = results_seen;
    test_begin();
    for (int i = 0; i < n_back_to_back; i++) begin
      if (rand32() % 4 != 0) begin
        f6 = pick_funct6(int'(rand32() % 5));
        issue(1'b1, f6, pick_funct3(int'(rand32() % ((f6 == funct6_vmerge_vmv) ? 3 : 2))),
              rand_bit(), rand_eew(), "back_to_back");
      end else begin
        idle("back_to_back");
      end
    end
    repeat (n_drain) idle("back_to_back");
    check("back_to_back result count", vreg_t'(valid_issued - issued_before),
          vreg_t'(results_seen - seen_before));
    test_end("back_to_back");
  endtask

  // outputs settle after the rising edge, so compare on the falling one
  always @(negedge clk) begin
    if (result_valid === 1'b1) begin
      results_seen++;
    end
    while (exp_q.size() > 0 && exp_q[0].due <= edge_count) begin
      cur = exp_q.pop_front();
      if (cur.due != edge_count) begin
        $display("%s: an expected response was skipped in its own cycle", cur.name);
        fail_count++;
      end else begin
        check({cur.name, " result_valid"}, vreg_t'(cur.valid), vreg_t'(result_valid));
        if (cur.valid) begin
          check({cur.name, " result_data"}, cur.data, result_data);
          check({cur.name, " result_rob_entry"}, vreg_t'(cur.rob_entry),
                vreg_t'(result_rob_entry));
          check({cur.name, " result_ignore_vma"}, vreg_t'(cur.ignore_vma),
                vreg_t'(result_ignore_vma));
        end
      end
    end
  end

  initial begin
    #((total_uops + 50) * clk_period);
    $display("timeout: the run did not finish within %0d ns", (total_uops + 50) * clk_period);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    uop_valid = 1'b0;
    uop_rob_entry = '0;
    uop_funct6 = '0;
    uop_funct3 = '0;
    uop_vm = 1'b0;
    uop_eew = eew8;
    uop_index = '0;
    vs1_data = '0;
    vs2_data = '0;
    rs1_data = '0;
    v0_data = '0;

    test_begin();
    repeat (3) idle("reset_idle");
    rst_n <= 1'b1;
    repeat (n_idle) idle("reset_idle");
    test_end("reset_idle");

    run_minmax(opivv, "minmax_vv");
    run_minmax(opivx, "minmax_vx");
    run_merge_move();
    run_unsupported();
    run_back_to_back();

    $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
